// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_frame_check_top --Mdir obj_dir -o sim_frame_check

output=$(./obj_dir/sim_frame_check)
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi

// ==== source/adapter_state_pkg.sv ====
package adapter_state_pkg;

  typedef enum logic [1:0] {
    idle,
    transfer_in,
    transfer_out
  } adapter_state_t;

  // frame_start means the next accepted word opens a frame.
  typedef enum logic {
    in_frame,
    frame_start
  } check_state_t;

endpackage

// ==== source/axis_adapter.sv ====
`timescale 1ns/1ns

module axis_adapter
  import stream_width_pkg::*;
  import adapter_state_pkg::*;
#(
  parameter int in_bytes = narrow_bytes,
  parameter int out_bytes = wide_bytes
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [in_bytes*byte_bits-1:0]  in_data,
  input  logic [in_bytes-1:0]            in_keep,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic                          in_last,
  input  logic                          in_user,
  output logic [out_bytes*byte_bits-1:0] out_data,
  output logic [out_bytes-1:0]           out_keep,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic                          out_last,
  output logic                          out_user
);

  localparam bit expand = out_bytes > in_bytes;
  localparam int data_bytes = expand ? out_bytes : in_bytes;
  localparam int data_bits = data_bytes * byte_bits;
  localparam int ratio = expand ? out_bytes / in_bytes : in_bytes / out_bytes;
  localparam int seg_bytes = data_bytes / ratio; // lanes of the narrow side.
  localparam int seg_bits = seg_bytes * byte_bits;
  localparam int cnt_w = $clog2(ratio + 1);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(ratio - 1);

  adapter_state_t state_reg, state_next;
  logic [cnt_w-1:0] cnt_reg, cnt_next;
  logic [data_bits-1:0] hold_data_reg, hold_data_next;
  logic [data_bytes-1:0] hold_keep_reg, hold_keep_next;
  logic hold_last_reg, hold_last_next;
  logic hold_user_reg, hold_user_next;
  logic in_ready_reg, in_ready_next;

  // beat offered to the output stage.
  logic [out_bytes*byte_bits-1:0] out_data_int;
  logic [out_bytes-1:0] out_keep_int;
  logic out_valid_int;
  logic out_last_int;
  logic out_user_int;
  logic out_ready_int;
  logic out_ready_int_early;

  assign in_ready = in_ready_reg;

  // ####################
  // packing / unpacking core
  // ####################

  generate
    if (in_bytes == out_bytes) begin : g_pass
      always_comb begin
        state_next = idle;
        cnt_next = cnt_reg;
        hold_data_next = hold_data_reg;
        hold_keep_next = hold_keep_reg;
        hold_last_next = hold_last_reg;
        hold_user_next = hold_user_reg;
        in_ready_next = out_ready_int_early;
        out_data_int = in_data;
        out_keep_int = in_keep;
        out_valid_int = in_valid && in_ready_reg;
        out_last_int = in_last;
        out_user_int = in_user;
      end
    end else if (expand) begin : g_up
      logic start_word;

      // a new word opens from idle, or straight after the held word leaves.
      assign start_word = in_ready_reg && in_valid &&
                          (state_reg == idle ||
                           (state_reg == transfer_out && out_ready_int));

      always_comb begin
        state_next = state_reg;
        cnt_next = cnt_reg;
        hold_data_next = hold_data_reg;
        hold_keep_next = hold_keep_reg;
        hold_last_next = hold_last_reg;
        hold_user_next = hold_user_reg;
        in_ready_next = 1'b0;
        out_data_int = hold_data_reg;
        out_keep_int = hold_keep_reg;
        out_valid_int = 1'b0;
        out_last_int = hold_last_reg;
        out_user_int = hold_user_reg;
        case (state_reg)
          idle: begin
            in_ready_next = 1'b1;
          end
          transfer_in: begin
            in_ready_next = 1'b1;
            if (in_ready_reg && in_valid) begin
              hold_data_next[cnt_reg*seg_bits +: seg_bits] = in_data;
              hold_keep_next[cnt_reg*seg_bytes +: seg_bytes] = in_keep;
              hold_last_next = in_last;
              hold_user_next = in_user;
              cnt_next = cnt_reg + 1'b1;
              if (cnt_reg == last_cnt || in_last) begin
                in_ready_next = out_ready_int_early; // may take the next byte at once.
                state_next = transfer_out;
              end
            end
          end
          transfer_out: begin
            out_valid_int = 1'b1;
            if (out_ready_int) begin
              in_ready_next = 1'b1;
              state_next = idle;
            end
          end
          default: begin
            state_next = idle;
          end
        endcase

        if (start_word) begin
          hold_data_next = '0;
          hold_data_next[seg_bits-1:0] = in_data;
          hold_keep_next = '0; // unfilled lanes stay cleared.
          hold_keep_next[seg_bytes-1:0] = in_keep;
          hold_last_next = in_last;
          hold_user_next = in_user;
          cnt_next = cnt_w'(1);
          if (in_last) begin
            in_ready_next = 1'b0;
            state_next = transfer_out;
          end else begin
            in_ready_next = 1'b1;
            state_next = transfer_in;
          end
        end
      end
    end else begin : g_down
      logic [data_bits-1:0] src_data;
      logic [data_bytes-1:0] src_keep;
      logic [data_bytes-1:0] rest_keep;
      logic src_last;
      logic src_user;
      logic [cnt_w-1:0] seg_idx;
      logic last_seg;

      // first segment comes from the input, later ones from the held word.
      always_comb begin
        if (state_reg == idle) begin
          src_data = in_data;
          src_keep = in_keep;
          src_last = in_last;
          src_user = in_user;
          seg_idx = '0;
        end else begin
          src_data = hold_data_reg;
          src_keep = hold_keep_reg;
          src_last = hold_last_reg;
          src_user = hold_user_reg;
          seg_idx = cnt_reg;
        end
        rest_keep = src_keep >> ((seg_idx + 1) * seg_bytes);
        last_seg = (seg_idx == last_cnt) ||
                   (src_keep[seg_idx*seg_bytes +: seg_bytes] != '1) ||
                   (rest_keep[seg_bytes-1:0] == '0);
      end

      always_comb begin
        state_next = state_reg;
        cnt_next = cnt_reg;
        hold_data_next = hold_data_reg;
        hold_keep_next = hold_keep_reg;
        hold_last_next = hold_last_reg;
        hold_user_next = hold_user_reg;
        in_ready_next = 1'b0;
        out_data_int = src_data[seg_idx*seg_bits +: seg_bits];
        out_keep_int = src_keep[seg_idx*seg_bytes +: seg_bytes];
        out_valid_int = 1'b0;
        out_last_int = src_last && last_seg; // only on the final kept lane.
        out_user_int = src_user && last_seg;
        case (state_reg)
          idle: begin
            in_ready_next = 1'b1;
            if (in_ready_reg && in_valid) begin
              hold_data_next = in_data;
              hold_keep_next = in_keep;
              hold_last_next = in_last;
              hold_user_next = in_user;
              out_valid_int = 1'b1;
              cnt_next = out_ready_int ? cnt_w'(1) : '0;
              if (!last_seg || !out_ready_int) begin
                in_ready_next = 1'b0;
                state_next = transfer_out;
              end
            end
          end
          transfer_out: begin
            out_valid_int = 1'b1;
            if (out_ready_int) begin
              cnt_next = cnt_reg + 1'b1;
              if (last_seg) begin
                in_ready_next = 1'b1;
                state_next = idle;
              end
            end
          end
          default: begin
            state_next = idle;
          end
        endcase
      end
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (rst) begin
      state_reg <= idle;
      cnt_reg <= '0;
      in_ready_reg <= 1'b0;
    end else begin
      state_reg <= state_next;
      cnt_reg <= cnt_next;
      in_ready_reg <= in_ready_next;
    end
  end

  always_ff @(posedge clk) begin
    hold_data_reg <= hold_data_next;
    hold_keep_reg <= hold_keep_next;
    hold_last_reg <= hold_last_next;
    hold_user_reg <= hold_user_next;
  end

  // ####################
  // output register and skid entry
  // ####################

  logic [out_bytes*byte_bits-1:0] out_data_reg, skid_data_reg;
  logic [out_bytes-1:0] out_keep_reg, skid_keep_reg;
  logic out_valid_reg, skid_valid_reg;
  logic out_last_reg, skid_last_reg;
  logic out_user_reg, skid_user_reg;

  // room for one more beat next cycle.
  assign out_ready_int_early = out_ready ||
                               (!skid_valid_reg && (!out_valid_reg || !out_valid_int));

  assign out_data = out_data_reg;
  assign out_keep = out_keep_reg;
  assign out_valid = out_valid_reg;
  assign out_last = out_last_reg;
  assign out_user = out_user_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_reg <= 1'b0;
      skid_valid_reg <= 1'b0;
      out_ready_int <= 1'b0;
    end else begin
      out_ready_int <= out_ready_int_early;
      if (out_ready_int) begin
        if (out_ready || !out_valid_reg) begin
          out_valid_reg <= out_valid_int;
        end else begin
          skid_valid_reg <= out_valid_int;
        end
      end else if (out_ready) begin
        out_valid_reg <= skid_valid_reg;
        skid_valid_reg <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_ready_int) begin
      if (out_ready || !out_valid_reg) begin
        out_data_reg <= out_data_int;
        out_keep_reg <= out_keep_int;
        out_last_reg <= out_last_int;
        out_user_reg <= out_user_int;
      end else begin
        skid_data_reg <= out_data_int;
        skid_keep_reg <= out_keep_int;
        skid_last_reg <= out_last_int;
        skid_user_reg <= out_user_int;
      end
    end else if (out_ready) begin
      out_data_reg <= skid_data_reg;
      out_keep_reg <= skid_keep_reg;
      out_last_reg <= skid_last_reg;
      out_user_reg <= skid_user_reg;
    end
  end

endmodule

// ==== source/frame_check_top.sv ====
`timescale 1ns/1ns

module frame_check_top
  import stream_width_pkg::*;
#(
  parameter int narrow_bytes = stream_width_pkg::narrow_bytes,
  parameter int wide_bytes = stream_width_pkg::wide_bytes
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [narrow_bytes*byte_bits-1:0] s_data,
  input  logic                             s_valid,
  output logic                             s_ready,
  input  logic                             s_last,
  input  logic                             s_user,
  output logic [narrow_bytes*byte_bits-1:0] m_data,
  output logic                             m_valid,
  input  logic                             m_ready,
  output logic                             m_last,
  output logic                             m_user
);

  // ####################
  // internal wide links
  // ####################

  logic [wide_bytes*byte_bits-1:0] up_data;
  logic [wide_bytes-1:0] up_keep;
  logic up_valid;
  logic up_ready;
  logic up_last;
  logic up_user;

  logic [wide_bytes*byte_bits-1:0] chk_data;
  logic [wide_bytes-1:0] chk_keep;
  logic chk_valid;
  logic chk_ready;
  logic chk_last;
  logic chk_user;

  axis_adapter #(
    .in_bytes  (narrow_bytes),
    .out_bytes (wide_bytes)
  ) upsizer_inst (
    .clk       (clk),
    .rst       (rst),
    .in_data   (s_data),
    .in_keep   ({narrow_bytes{1'b1}}), // narrow side is always a full byte.
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .in_last   (s_last),
    .in_user   (s_user),
    .out_data  (up_data),
    .out_keep  (up_keep),
    .out_valid (up_valid),
    .out_ready (up_ready),
    .out_last  (up_last),
    .out_user  (up_user)
  );

  frame_checksum #(
    .lanes (wide_bytes)
  ) checksum_inst (
    .clk       (clk),
    .rst       (rst),
    .in_data   (up_data),
    .in_keep   (up_keep),
    .in_valid  (up_valid),
    .in_ready  (up_ready),
    .in_last   (up_last),
    .in_user   (up_user),
    .out_data  (chk_data),
    .out_keep  (chk_keep),
    .out_valid (chk_valid),
    .out_ready (chk_ready),
    .out_last  (chk_last),
    .out_user  (chk_user)
  );

  axis_adapter #(
    .in_bytes  (wide_bytes),
    .out_bytes (narrow_bytes)
  ) downsizer_inst (
    .clk       (clk),
    .rst       (rst),
    .in_data   (chk_data),
    .in_keep   (chk_keep),
    .in_valid  (chk_valid),
    .in_ready  (chk_ready),
    .in_last   (chk_last),
    .in_user   (chk_user),
    .out_data  (m_data),
    .out_keep  (),
    .out_valid (m_valid),
    .out_ready (m_ready),
    .out_last  (m_last),
    .out_user  (m_user)
  );

endmodule

// ==== source/frame_checksum.sv ====
`timescale 1ns/1ns

module frame_checksum
  import stream_width_pkg::*;
  import adapter_state_pkg::*;
#(
  parameter int lanes = wide_bytes
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [lanes*byte_bits-1:0] in_data,
  input  logic [lanes-1:0]           in_keep,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic                      in_last,
  input  logic                      in_user,
  output logic [lanes*byte_bits-1:0] out_data,
  output logic [lanes-1:0]           out_keep,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic                      out_last,
  output logic                      out_user
);

  check_state_t state_reg;
  logic [byte_bits-1:0] sum_reg;
  logic [byte_bits-1:0] word_sum;
  logic [byte_bits-1:0] frame_sum;
  logic user_int;
  logic accept;
  logic load_out;
  logic in_ready_reg;
  logic skid_valid_next;
  logic [lanes*byte_bits-1:0] out_data_reg, skid_data_reg;
  logic [lanes-1:0] out_keep_reg, skid_keep_reg;
  logic out_valid_reg, skid_valid_reg;
  logic out_last_reg, skid_last_reg;
  logic out_user_reg, skid_user_reg;

  assign accept = in_valid && in_ready_reg;
  assign load_out = out_ready || !out_valid_reg;

  // kept bytes of this word, folded onto the running sum.
  always_comb begin
    word_sum = '0;
    for (int i = 0; i < lanes; i++) begin
      if (in_keep[i]) begin
        word_sum = word_sum + in_data[i*byte_bits +: byte_bits];
      end
    end
    frame_sum = word_sum + ((state_reg == frame_start) ? '0 : sum_reg);
  end

  assign user_int = in_user || (in_last && frame_sum != '0); // bad sum flags the frame.

  // skid fills only while the output register is stalled.
  always_comb begin
    if (load_out) skid_valid_next = 1'b0;
    else skid_valid_next = skid_valid_reg || accept;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_reg <= frame_start;
      out_valid_reg <= 1'b0;
      skid_valid_reg <= 1'b0;
      in_ready_reg <= 1'b0;
    end else begin
      if (accept) state_reg <= in_last ? frame_start : in_frame;
      if (load_out) out_valid_reg <= skid_valid_reg || accept;
      skid_valid_reg <= skid_valid_next;
      in_ready_reg <= !skid_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) sum_reg <= frame_sum;
    if (load_out) begin
      if (skid_valid_reg) begin
        out_data_reg <= skid_data_reg;
        out_keep_reg <= skid_keep_reg;
        out_last_reg <= skid_last_reg;
        out_user_reg <= skid_user_reg;
      end else begin
        out_data_reg <= in_data;
        out_keep_reg <= in_keep;
        out_last_reg <= in_last;
        out_user_reg <= user_int;
      end
    end else if (accept) begin
      skid_data_reg <= in_data;
      skid_keep_reg <= in_keep;
      skid_last_reg <= in_last;
      skid_user_reg <= user_int;
    end
  end

  assign in_ready = in_ready_reg;
  assign out_data = out_data_reg;
  assign out_keep = out_keep_reg;
  assign out_valid = out_valid_reg;
  assign out_last = out_last_reg;
  assign out_user = out_user_reg;

endmodule

// ==== source/stream_width_pkg.sv ====
package stream_width_pkg;

  // ####################
  // lane counts of the streams.
  // ####################

  parameter int narrow_bytes = 1; // outer byte streams.
  parameter int wide_bytes = 4;   // packed internal stream.

  // bits carried per lane.
  parameter int byte_bits = 8;

endpackage

// ==== tb/frame_check_assert.sv ====
`timescale 1ns/1ns

module frame_check_assert
  import stream_width_pkg::*;
#(
  parameter int narrow_bytes = stream_width_pkg::narrow_bytes
) (
  input logic                             clk,
  input logic                             rst,
  input logic                             s_ready,
  input logic [narrow_bytes*byte_bits-1:0] m_data,
  input logic                             m_valid,
  input logic                             m_ready,
  input logic                             m_last,
  input logic                             m_user
);

  // stalled beat must hold.
  assert property (@(posedge clk) disable iff (rst)
    (m_valid && !m_ready) |=> ($stable(m_data) && $stable(m_last) && $stable(m_user)))
    else $error("m_data, m_last or m_user changed while stalled");

  assert property (@(posedge clk) disable iff (rst) (m_valid && !m_ready) |=> m_valid)
    else $error("m_valid dropped without a transfer");

  assert property (@(posedge clk) rst |=> (!s_ready && !m_valid)) // also the cycle after.
    else $error("s_ready or m_valid high right after reset");

endmodule

bind frame_check_top frame_check_assert #(
  .narrow_bytes (narrow_bytes)
) assert_inst (
  .clk     (clk),
  .rst     (rst),
  .s_ready (s_ready),
  .m_data  (m_data),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_last  (m_last),
  .m_user  (m_user)
);

// ==== tb/tb_frame_check_top.sv ====
`timescale 1ns/1ns

module tb_frame_check_top
  import stream_width_pkg::*;
();

  localparam int clk_period = 20;
  localparam int reset_cycles = 8;
  localparam logic [31:0] lfsr_seed = 32'hb983_bec0;
  localparam int cycles_per_byte = 40;
  localparam int watchdog_margin = 500;
  localparam int drain_cycles = 200;
  localparam string data_file = "tb/testdata_frames.txt";
  localparam int rec_bits = narrow_bytes * byte_bits + 2; // byte, last, user.

  logic clk;
  logic rst;
  logic [narrow_bytes*byte_bits-1:0] s_data;
  logic s_valid;
  logic s_ready;
  logic s_last;
  logic s_user;
  logic [narrow_bytes*byte_bits-1:0] m_data;
  logic m_valid;
  logic m_ready;
  logic m_last;
  logic m_user;

  logic [rec_bits-1:0] in_q[$];
  logic [rec_bits-1:0] exp_q[$];
  logic [31:0] gap_lfsr;
  logic [31:0] stall_lfsr;
  int value_errors;
  int other_errors;
  int out_count;
  bit loaded;

  frame_check_top #(
    .narrow_bytes (narrow_bytes),
    .wide_bytes   (wide_bytes)
  ) frame_check_top_inst (
    .clk     (clk),
    .rst     (rst),
    .s_data  (s_data),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_user  (s_user),
    .m_data  (m_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_user  (m_user)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ####################
  // helpers
  // ####################

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0]; // x^32+x^22+x^2+x+1.
    return {state[30:0], fb};
  endfunction

  task automatic take_bit(inout logic [31:0] state, output logic b);
    state = lfsr_next(state);
    b = state[0];
  endtask

  task automatic load_records();
    int fd;
    int n;
    string line;
    logic [narrow_bytes*byte_bits-1:0] b;
    int l;
    int u;
    fd = $fopen(data_file, "r");
    if (fd == 0) begin
      $display("could not open the data file %s", data_file);
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 7 || line[0] == "#") continue;
      n = $sscanf(line.substr(2, line.len() - 1), "%h %d %d", b, l, u);
      if (n != 3) begin
        $display("malformed line in the data file: %s", line);
        other_errors++;
      end else if (line[0] == "i") begin
        in_q.push_back({b, l[0], u[0]});
      end else begin
        exp_q.push_back({b, l[0], u[0]});
      end
    end
    $fclose(fd);
    if (in_q.size() == 0) begin
      $display("the data file holds no input bytes");
      other_errors++;
    end
  endtask

  task automatic check_reset_outputs();
    if (s_ready !== 1'b0) begin
      $display("[ERROR] s_ready in reset expected 0x0 got 0x%h", s_ready);
      value_errors++;
    end
    if (m_valid !== 1'b0) begin
      $display("[ERROR] m_valid in reset expected 0x0 got 0x%h", m_valid);
      value_errors++;
    end
  endtask

  task automatic drive_frames();
    logic [rec_bits-1:0] rec;
    logic b0;
    logic b1;
    for (int i = 0; i < in_q.size(); i++) begin
      rec = in_q[i];
      take_bit(gap_lfsr, b0);
      take_bit(gap_lfsr, b1);
      while (b0 && b1) begin // idle gap, one cycle in four.
        s_valid = 1'b0;
        @(negedge clk);
        take_bit(gap_lfsr, b0);
        take_bit(gap_lfsr, b1);
      end
      s_data = rec[rec_bits-1:2];
      s_last = rec[1];
      s_user = rec[0];
      s_valid = 1'b1;
      while (!s_ready) @(negedge clk);
      @(negedge clk); // accepted on the edge just passed.
    end
    s_valid = 1'b0;
    s_last = 1'b0;
    s_user = 1'b0;
  endtask

  task automatic wait_for_drain();
    int idle;
    idle = 0;
    while (exp_q.size() != 0 && idle < drain_cycles) begin
      @(negedge clk);
      idle++;
    end
    repeat (20) @(negedge clk); // surplus bytes would show here.
    if (exp_q.size() != 0) begin
      $display("%0d expected output bytes never appeared", exp_q.size());
      other_errors++;
    end
  endtask

  task automatic finish_run();
    $display("errors: value %0d, other %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // ####################
  // processes
  // ####################

  initial begin
    rst = 1'b1;
    s_data = '0;
    s_valid = 1'b0;
    s_last = 1'b0;
    s_user = 1'b0;
    m_ready = 1'b0;
    gap_lfsr = lfsr_seed;
    value_errors = 0;
    other_errors = 0;
    out_count = 0;
    load_records();
    loaded = 1'b1;
    repeat (reset_cycles) begin
      @(negedge clk);
      check_reset_outputs();
    end
    rst = 1'b0;
    drive_frames();
    wait_for_drain();
    finish_run();
  end

  // random back-pressure, ready three cycles in four.
  initial begin : stall_gen
    logic b0;
    logic b1;
    stall_lfsr = lfsr_seed;
    forever begin
      @(negedge clk);
      take_bit(stall_lfsr, b0);
      take_bit(stall_lfsr, b1);
      m_ready = !(b0 && b1);
    end
  end

  always @(posedge clk) begin : monitor
    logic [rec_bits-1:0] exp_rec;
    if (!rst && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        $display("unexpected output byte 0x%h after all expected bytes", m_data);
        other_errors++;
      end else begin
        exp_rec = exp_q.pop_front();
        if (m_data !== exp_rec[rec_bits-1:2]) begin
          $display("[ERROR] byte %0d m_data expected 0x%h got 0x%h",
                   out_count, exp_rec[rec_bits-1:2], m_data);
          value_errors++;
        end
        if (m_last !== exp_rec[1]) begin
          $display("[ERROR] byte %0d m_last expected 0x%h got 0x%h",
                   out_count, exp_rec[1], m_last);
          value_errors++;
        end
        if (m_user !== exp_rec[0]) begin
          $display("[ERROR] byte %0d m_user expected 0x%h got 0x%h",
                   out_count, exp_rec[0], m_user);
          value_errors++;
        end
      end
      out_count++;
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (reset_cycles + in_q.size() * cycles_per_byte + watchdog_margin) @(posedge clk);
    $display("watchdog timeout, the frames did not finish in time");
    other_errors++;
    finish_run();
  end

endmodule

// ==== tb/testdata_frames.txt ====
# columns: kind (i = byte into s_*, o = expected byte on m_*), byte hex, last, user
# frames of 1 to 6 bytes, sums 00, 00, 06, 00 with s_user, 00, fe
i 00 1 0
o 00 1 0
i 10 0 0
i f0 1 0
o 10 0 0
o f0 1 0
i 01 0 0
i 02 0 0
i 03 1 0
o 01 0 0
o 02 0 0
o 03 1 1
i 40 0 0
i 40 0 0
i 40 0 0
i 40 1 1
o 40 0 0
o 40 0 0
o 40 0 0
o 40 1 1
i 11 0 0
i 22 0 0
i 33 0 0
i 44 0 0
i 56 1 0
o 11 0 0
o 22 0 0
o 33 0 0
o 44 0 0
o 56 1 0
i a5 0 0
i 5a 0 0
i ff 0 0
i 01 0 0
i 80 0 0
i 7f 1 0
o a5 0 0
o 5a 0 0
o ff 0 0
o 01 0 0
o 80 0 0
o 7f 1 1

// ==== verilog.f ====
source/stream_width_pkg.sv
source/adapter_state_pkg.sv
source/axis_adapter.sv
source/frame_checksum.sv
source/frame_check_top.sv
tb/frame_check_assert.sv
tb/tb_frame_check_top.sv
